// ==== files.f ====
+incdir+hw
hw/mem_stage_pkg.sv
hw/mem_access_seq.sv
hw/mem_stage.sv
hw/wb_byte_arbiter.sv
hw/byte_ram.sv
hw/mem_sys_top.sv
tests/mem_sys_chk.sv
tests/mem_sys_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the memory system testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f files.f --top-module mem_sys_tb -o mem_sys_sim
if [ $? -ne 0 ]; then
    echo "Build failed"
    exit 1
fi

./obj_dir/mem_sys_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "ERRORS FOUND" "$LOG"; then
    echo "Simulation reported failures"
    exit 1
fi

echo "Simulation passed"
exit 0

// ==== tests/mem_sys_tb.sv ====
`include "mem_stage_params.svh"

module mem_sys_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import mem_stage_pkg::*;

    localparam int NUM_ENTRIES = 20;
    localparam int RESET_CYCLES = 10;
    localparam int TIMEOUT = (NUM_ENTRIES + 1) * 16 + RESET_CYCLES;
    localparam logic [`RAM_ADDR_W-1:0] ADDR_A = 10'h040;
    localparam logic [`RAM_ADDR_W-1:0] ADDR_B = 10'h123;

    typedef struct packed {
        mem_op_e                op;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`XLEN-1:0]       alu;
        logic [`XLEN-1:0]       sdata;
        mem_wb_t                exp;
    } entry_t;

    logic                   clk;
    logic                   rst_n_i;
    ex_mem_t                ex_i;
    mem_wb_t                wb_o;
    logic                   stall_o;
    logic                   fetch_req_i;
    logic [`RAM_ADDR_W-1:0] fetch_addr_i;
    logic                   fetch_busy_o;
    logic                   fetch_valid_o;
    logic [`XLEN-1:0]       fetch_word_o;

    entry_t             table_q [NUM_ENTRIES];
    logic [`BYTE_W-1:0] model_mem [`RAM_DEPTH];
    int                 n_built = 0;
    int                 errors = 0;
    int                 cycles = 0;
    int                 seed = 32'h26f5_2a41;

    mem_sys_top u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT) begin
            $display("Timeout, the run did not finish within %0d cycles", TIMEOUT);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    ////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////

    function automatic logic [`XLEN-1:0] model_read(input mem_op_e op,
                                                    input logic [`RAM_ADDR_W-1:0] addr);
        logic [`XLEN-1:0] raw;
        for (int i = 0; i < 4; i++) begin
            raw[i*8 +: 8] = model_mem[addr + `RAM_ADDR_W'(i)];
        end
        case (op)
            LB:      return {{24{raw[7]}}, raw[7:0]};
            LBU:     return {24'h0, raw[7:0]};
            LH:      return {{16{raw[15]}}, raw[15:0]};
            LHU:     return {16'h0, raw[15:0]};
            default: return raw;
        endcase
    endfunction

    function automatic entry_t make_entry(input mem_op_e op,
                                          input logic [`REG_ADDR_W-1:0] rd,
                                          input logic [`XLEN-1:0] alu,
                                          input logic [`XLEN-1:0] sdata);
        entry_t e;
        int     n;
        e = '{op: op, rd: rd, alu: alu, sdata: sdata, exp: '0};
        e.exp.valid = 1'b1;
        e.exp.rd    = rd;
        n = (op == SB) ? 1 : (op == SH) ? 2 : 4;
        if (op == NONE) begin
            e.exp.we    = 1'b1;
            e.exp.wdata = alu;
        end else if (op inside {SB, SH, SW}) begin
            // Stores give no register write
            for (int i = 0; i < n; i++) begin
                model_mem[alu[`RAM_ADDR_W-1:0] + `RAM_ADDR_W'(i)] = sdata[i*8 +: 8];
            end
        end else begin
            e.exp.we    = 1'b1;
            e.exp.wdata = model_read(op, alu[`RAM_ADDR_W-1:0]);
        end
        return e;
    endfunction

    task automatic add_entry(input mem_op_e op, input logic [`XLEN-1:0] alu,
                             input logic [`XLEN-1:0] sdata);
        table_q[n_built] = make_entry(op, 5'(n_built + 1), alu, sdata);
        n_built++;
    endtask

    ////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////

    task automatic check_wb(input string name, input mem_wb_t got, input mem_wb_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_fetch(input string name, input logic [`XLEN-1:0] got,
                               input logic [`XLEN-1:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    ////////////////////////////////////////
    // Drivers
    ////////////////////////////////////////

    task automatic drive_ex(input entry_t e);
        ex_i = '{valid: 1'b1, op: e.op, rf_we: 1'b1, rd: e.rd, alu: e.alu, sdata: e.sdata};
    endtask

    task automatic wait_wb();
        do @(negedge clk); while (!wb_o.valid);
    endtask

    // Entered and left on a falling edge
    task automatic apply_entry(input entry_t e);
        drive_ex(e);
        @(negedge clk);
        if (e.op == NONE) begin
            check_flag("stall_o", stall_o, 1'b0);
        end else begin
            // Stall holds until the done cycle, result follows one cycle later
            check_flag("stall_o", stall_o, 1'b1);
            while (stall_o) begin
                @(negedge clk);
            end
            @(negedge clk);
        end
        check_wb("wb_o", wb_o, e.exp);
    endtask

    // Fetch and data load requested in the same cycle
    task automatic run_fetch_race();
        entry_t           e;
        logic [`XLEN-1:0] exp_word;
        e = make_entry(LW, 5'd30, {22'h0, ADDR_B}, '0);
        exp_word = model_read(LW, ADDR_A);
        fetch_req_i  = 1'b1;
        fetch_addr_i = ADDR_A;
        drive_ex(e);
        fork
            begin
                @(negedge clk);
                fetch_req_i = 1'b0;
                check_flag("fetch_busy_o", fetch_busy_o, 1'b1);
                do @(negedge clk); while (!fetch_valid_o);
                check_fetch("fetch_word_o", fetch_word_o, exp_word);
            end
            begin
                wait_wb();
                check_wb("wb_o", wb_o, e.exp);
                ex_i = '0;
            end
        join
    endtask

    initial begin
        logic [`XLEN-1:0] word;
        rst_n_i      = 1'b0;
        ex_i         = '0;
        fetch_req_i  = 1'b0;
        fetch_addr_i = '0;

        // Bytes 0 and 3 negative, half 0 positive, half 1 negative
        word = ($random(seed) & 32'h7f7f_7f7f) | 32'h8000_0080;
        add_entry(NONE, $random(seed), '0);
        add_entry(SW, {22'h0, ADDR_A}, word);
        add_entry(LW, {22'h0, ADDR_A}, '0);
        for (int i = 0; i < 4; i++) begin
            add_entry(LB, {22'h0, ADDR_A + 10'(i)}, '0);
            add_entry(LBU, {22'h0, ADDR_A + 10'(i)}, '0);
        end
        for (int i = 0; i < 4; i += 2) begin
            add_entry(LH, {22'h0, ADDR_A + 10'(i)}, '0);
            add_entry(LHU, {22'h0, ADDR_A + 10'(i)}, '0);
        end
        add_entry(SB, {22'h0, ADDR_A + 10'd1}, $random(seed));
        add_entry(SH, {22'h0, ADDR_A + 10'd2}, $random(seed));
        add_entry(LW, {22'h0, ADDR_A}, '0);
        add_entry(SW, {22'h0, ADDR_B}, $random(seed));
        add_entry(NONE, $random(seed), '0);

        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n_i = 1'b1;

        repeat (3) begin
            @(negedge clk);
            check_flag("stall_o", stall_o, 1'b0);
            check_flag("wb_o.valid", wb_o.valid, 1'b0);
            check_flag("fetch_busy_o", fetch_busy_o, 1'b0);
            check_flag("fetch_valid_o", fetch_valid_o, 1'b0);
        end

        for (int i = 0; i < n_built; i++) begin
            apply_entry(table_q[i]);
        end
        ex_i = '0;
        @(negedge clk);
        run_fetch_race();

        @(negedge clk);
        errors += int'(u_dut.u_arb.u_chk.fail_cnt);
        $display("Error count %0d", errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// ==== tests/mem_sys_chk.sv ====
module mem_sys_chk (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  mem_stage_pkg::wb_req_t req_i,
    input  mem_stage_pkg::wb_rsp_t rsp_i,
    input  logic                   owner_i,
    input  logic                   owner_cyc_i
);
    timeunit 1ns;
    timeprecision 1ps;

    int unsigned fail_cnt = 0;

    ////////////////////////////////////////
    // RAM side of the arbiter
    ////////////////////////////////////////

    stb_needs_cyc: assert property (@(posedge clk) disable iff (!rst_n_i)
        req_i.stb |-> req_i.cyc)
        else begin fail_cnt++; $error("stb raised without cyc"); end

    ack_after_stb: assert property (@(posedge clk) disable iff (!rst_n_i)
        rsp_i.ack |-> $past(req_i.cyc && req_i.stb))
        else begin fail_cnt++; $error("ack without stb in the cycle before"); end

    // Address held until the slave answers
    adr_stable: assert property (@(posedge clk) disable iff (!rst_n_i)
        (req_i.stb && !rsp_i.ack) |=> $stable(req_i.adr))
        else begin fail_cnt++; $error("address changed while waiting for ack"); end

    owner_locked: assert property (@(posedge clk) disable iff (!rst_n_i)
        owner_cyc_i |=> $stable(owner_i))
        else begin fail_cnt++; $error("owner changed while its cyc was high"); end

endmodule

bind wb_byte_arbiter mem_sys_chk u_chk (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .req_i       (ram_req_o),
    .rsp_i       (ram_rsp_i),
    .owner_i     (owner_q),
    .owner_cyc_i (owner_cyc)
);

// ==== hw/mem_sys_top.sv ====
`include "mem_stage_params.svh"

module mem_sys_top (
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  mem_stage_pkg::ex_mem_t  ex_i,
    output mem_stage_pkg::mem_wb_t  wb_o,
    output logic                    stall_o,
    input  logic                    fetch_req_i,
    input  logic [`RAM_ADDR_W-1:0]  fetch_addr_i,
    output logic                    fetch_busy_o,
    output logic                    fetch_valid_o,
    output logic [`XLEN-1:0]        fetch_word_o
);
    import mem_stage_pkg::*;

    access_t          data_acc;
    access_t          fetch_acc;
    wb_req_t          data_req;
    wb_req_t          fetch_req;
    wb_req_t          ram_req;
    wb_rsp_t          data_rsp;
    wb_rsp_t          fetch_rsp;
    wb_rsp_t          ram_rsp;
    logic             data_done;
    logic [`XLEN-1:0] data_rdata;

    // Fetch always reads a full instruction word
    assign fetch_acc = '{start: fetch_req_i, op: LW, addr: fetch_addr_i, sdata: '0};

    mem_stage u_stage (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .ex_i    (ex_i),
        .wb_o    (wb_o),
        .stall_o (stall_o),
        .acc_o   (data_acc),
        .done_i  (data_done),
        .rdata_i (data_rdata)
    );

    mem_access_seq u_data_seq (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .req_i   (data_acc),
        .bus_o   (data_req),
        .bus_i   (data_rsp),
        .done_o  (data_done),
        .busy_o  (),
        .rdata_o (data_rdata)
    );

    mem_access_seq u_fetch_seq (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .req_i   (fetch_acc),
        .bus_o   (fetch_req),
        .bus_i   (fetch_rsp),
        .done_o  (fetch_valid_o),
        .busy_o  (fetch_busy_o),
        .rdata_o (fetch_word_o)
    );

    wb_byte_arbiter u_arb (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .data_req_i  (data_req),
        .fetch_req_i (fetch_req),
        .data_rsp_o  (data_rsp),
        .fetch_rsp_o (fetch_rsp),
        .ram_req_o   (ram_req),
        .ram_rsp_i   (ram_rsp)
    );

    byte_ram u_ram (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .req_i   (ram_req),
        .rsp_o   (ram_rsp)
    );

endmodule

// ==== hw/byte_ram.sv ====
`include "mem_stage_params.svh"

module byte_ram (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  mem_stage_pkg::wb_req_t req_i,
    output mem_stage_pkg::wb_rsp_t rsp_o
);

    logic [`BYTE_W-1:0] mem_q [`RAM_DEPTH];
    logic [`BYTE_W-1:0] rdata_q;
    logic               ack_q;
    logic               access;

    // No new access in the ack cycle
    assign access = req_i.cyc && req_i.stb && !ack_q;

    ////////////////////////////////////////
    // Storage
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (access) begin
            if (req_i.we) begin
                mem_q[req_i.adr] <= req_i.dat;
            end
            rdata_q <= mem_q[req_i.adr];
        end
    end

    // Ack exactly one cycle after stb
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= access;
        end
    end

    assign rsp_o = '{ack: ack_q, dat: rdata_q};

endmodule

// ==== hw/wb_byte_arbiter.sv ====
module wb_byte_arbiter (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  mem_stage_pkg::wb_req_t data_req_i,
    input  mem_stage_pkg::wb_req_t fetch_req_i,
    output mem_stage_pkg::wb_rsp_t data_rsp_o,
    output mem_stage_pkg::wb_rsp_t fetch_rsp_o,
    output mem_stage_pkg::wb_req_t ram_req_o,
    input  mem_stage_pkg::wb_rsp_t ram_rsp_i
);

    localparam logic GNT_DATA  = 1'b0;
    localparam logic GNT_FETCH = 1'b1;

    logic owner_q;
    logic owner_cyc;
    logic grant;

    // Owner keeps the bus while its cyc stays high
    assign owner_cyc = (owner_q == GNT_FETCH) ? fetch_req_i.cyc : data_req_i.cyc;

    // Idle bus, data before fetch
    always_comb begin
        if (owner_cyc) begin
            grant = owner_q;
        end else if (data_req_i.cyc) begin
            grant = GNT_DATA;
        end else if (fetch_req_i.cyc) begin
            grant = GNT_FETCH;
        end else begin
            grant = owner_q;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            owner_q <= GNT_DATA;
        end else begin
            owner_q <= grant;
        end
    end

    ////////////////////////////////////////
    // Routing
    ////////////////////////////////////////

    // Only the granted master reaches the RAM
    assign ram_req_o = (grant == GNT_FETCH) ? fetch_req_i : data_req_i;

    always_comb begin
        data_rsp_o      = ram_rsp_i;
        fetch_rsp_o     = ram_rsp_i;
        data_rsp_o.ack  = ram_rsp_i.ack && (grant == GNT_DATA);
        fetch_rsp_o.ack = ram_rsp_i.ack && (grant == GNT_FETCH);
    end

endmodule

// ==== hw/mem_stage.sv ====
`include "mem_stage_params.svh"

module mem_stage (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  mem_stage_pkg::ex_mem_t ex_i,
    output mem_stage_pkg::mem_wb_t wb_o,
    output logic                   stall_o,
    output mem_stage_pkg::access_t acc_o,
    input  logic                   done_i,
    input  logic [`XLEN-1:0]       rdata_i
);
    import mem_stage_pkg::*;

    mem_wb_t          wb_q;
    logic             started_q;
    logic             is_mem;
    logic             is_load;
    logic [`XLEN-1:0] load_word;

    ////////////////////////////////////////
    // Decode and access request
    ////////////////////////////////////////

    assign is_mem  = ex_i.valid && (ex_i.op != NONE);
    assign is_load = ex_i.op inside {LB, LBU, LH, LHU, LW};

    // Execute holds ex_i until stall falls
    assign stall_o = is_mem && !done_i;

    always_comb begin
        acc_o.start = is_mem && !started_q;
        acc_o.op    = ex_i.op;
        acc_o.addr  = ex_i.alu[`RAM_ADDR_W-1:0];
        acc_o.sdata = ex_i.sdata;
    end

    // One start per memory instruction
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            started_q <= 1'b0;
        end else if (done_i) begin
            started_q <= 1'b0;
        end else if (acc_o.start) begin
            started_q <= 1'b1;
        end
    end

    // Raw word from the sequencer is zero padded
    always_comb begin
        case (ex_i.op)
            LB:      load_word = {{(`XLEN-`BYTE_W){rdata_i[`BYTE_W-1]}},
                                  rdata_i[`BYTE_W-1:0]};
            LBU:     load_word = {{(`XLEN-`BYTE_W){1'b0}}, rdata_i[`BYTE_W-1:0]};
            LH:      load_word = {{(`XLEN-2*`BYTE_W){rdata_i[2*`BYTE_W-1]}},
                                  rdata_i[2*`BYTE_W-1:0]};
            LHU:     load_word = {{(`XLEN-2*`BYTE_W){1'b0}}, rdata_i[2*`BYTE_W-1:0]};
            default: load_word = rdata_i;
        endcase
    end

    ////////////////////////////////////////
    // Write-back register
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            wb_q.valid <= 1'b0;
        end else begin
            wb_q.valid <= ex_i.valid && (!is_mem || done_i);
            wb_q.we    <= ex_i.rf_we && (!is_mem || is_load);
            wb_q.rd    <= ex_i.rd;
            if (!is_mem) begin
                wb_q.wdata <= ex_i.alu;
            end else if (is_load) begin
                wb_q.wdata <= load_word;
            end else begin
                wb_q.wdata <= '0;
            end
        end
    end

    assign wb_o = wb_q;

endmodule

// ==== hw/mem_access_seq.sv ====
`include "mem_stage_params.svh"

module mem_access_seq (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  mem_stage_pkg::access_t req_i,
    output mem_stage_pkg::wb_req_t bus_o,
    input  mem_stage_pkg::wb_rsp_t bus_i,
    output logic                   done_o,
    output logic                   busy_o,
    output logic [`XLEN-1:0]       rdata_o
);
    import mem_stage_pkg::*;

    seq_state_e             state_q;
    logic [1:0]             beat_q;
    logic                   busy_q;

    mem_op_e                op_q;
    logic [1:0]             last_q;
    logic [`RAM_ADDR_W-1:0] addr_q;
    logic [`XLEN-1:0]       sdata_q;
    logic [`XLEN-1:0]       rdata_q;

    logic                   accept;
    logic                   is_store;

    // Index of the final beat for each access size
    function automatic logic [1:0] last_beat(input mem_op_e op);
        case (op)
            LH, LHU, SH: last_beat = 2'd1;
            LW, SW:      last_beat = 2'd3;
            default:     last_beat = 2'd0;
        endcase
    endfunction

    assign accept   = (state_q == IDLE) && req_i.start;
    assign is_store = (op_q == SB) || (op_q == SH) || (op_q == SW);

    ////////////////////////////////////////
    // FSM
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q <= IDLE;
            beat_q  <= 2'd0;
            busy_q  <= 1'b0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (req_i.start) begin
                        state_q <= BEAT;
                        beat_q  <= 2'd0;
                        busy_q  <= 1'b1;
                    end
                end
                BEAT: begin
                    if (bus_i.ack) begin
                        if (beat_q == last_q) begin
                            state_q <= DONE;
                            busy_q  <= 1'b0;
                        end else begin
                            beat_q <= beat_q + 2'd1;
                        end
                    end
                end
                default: begin
                    state_q <= IDLE;
                end
            endcase
        end
    end

    // Access payload and load assembly
    always_ff @(posedge clk) begin
        if (accept) begin
            op_q    <= req_i.op;
            last_q  <= last_beat(req_i.op);
            addr_q  <= req_i.addr;
            sdata_q <= req_i.sdata;
            rdata_q <= '0;
        end else if ((state_q == BEAT) && bus_i.ack && !is_store) begin
            // Little endian, beat n lands in byte lane n
            rdata_q[beat_q*`BYTE_W +: `BYTE_W] <= bus_i.dat;
        end
    end

    ////////////////////////////////////////
    // Bus drive
    ////////////////////////////////////////

    // stb drops in the ack cycle, next beat follows directly
    always_comb begin
        bus_o.cyc = (state_q == BEAT);
        bus_o.stb = (state_q == BEAT) && !bus_i.ack;
        bus_o.we  = is_store;
        bus_o.adr = addr_q + `RAM_ADDR_W'(beat_q);
        bus_o.dat = sdata_q[beat_q*`BYTE_W +: `BYTE_W];
    end

    assign done_o  = (state_q == DONE);
    assign busy_o  = busy_q;
    assign rdata_o = rdata_q;

endmodule

// ==== hw/mem_stage_pkg.sv ====
`include "mem_stage_params.svh"

package mem_stage_pkg;

    ////////////////////////////////////////
    // Encodings
    ////////////////////////////////////////

    typedef enum logic [3:0] {
        NONE = 4'd0,
        LB   = 4'd1,
        LBU  = 4'd2,
        LH   = 4'd3,
        LHU  = 4'd4,
        LW   = 4'd5,
        SB   = 4'd6,
        SH   = 4'd7,
        SW   = 4'd8
    } mem_op_e;

    typedef enum logic [1:0] {
        IDLE = 2'd0,
        BEAT = 2'd1,
        DONE = 2'd2
    } seq_state_e;

    ////////////////////////////////////////
    // Pipeline
    ////////////////////////////////////////

    // alu is the byte address for memory ops
    typedef struct packed {
        logic                   valid;
        mem_op_e                op;
        logic                   rf_we;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`XLEN-1:0]       alu;
        logic [`XLEN-1:0]       sdata;
    } ex_mem_t;

    typedef struct packed {
        logic                   valid;
        logic                   we;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`XLEN-1:0]       wdata;
    } mem_wb_t;

    ////////////////////////////////////////
    // Wishbone and sequencer request
    ////////////////////////////////////////

    typedef struct packed {
        logic                   cyc;
        logic                   stb;
        logic                   we;
        logic [`RAM_ADDR_W-1:0] adr;
        logic [`BYTE_W-1:0]     dat;
    } wb_req_t;

    typedef struct packed {
        logic                   ack;
        logic [`BYTE_W-1:0]     dat;
    } wb_rsp_t;

    typedef struct packed {
        logic                   start;
        mem_op_e                op;
        logic [`RAM_ADDR_W-1:0] addr;
        logic [`XLEN-1:0]       sdata;
    } access_t;

endpackage

// ==== hw/mem_stage_params.svh ====
`ifndef MEM_STAGE_PARAMS_SVH
`define MEM_STAGE_PARAMS_SVH

// Register and data word
`define XLEN        32

// One memory byte lane
`define BYTE_W      8

// Destination register index
`define REG_ADDR_W  5

// Byte address on the bus
`define RAM_ADDR_W  10

// Bytes in the RAM
`define RAM_DEPTH   1024

`endif
